//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= fetch_unit_tb
FILELIST  ?= fetch_unit.f
BUILD     ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD)

//--- bench/fetch_mem_model.sv
`default_nettype none

module fetch_mem_model
  import fetch_types_pkg::*;
  import fetch_bus_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    rst,
  input  wire rd_req_t req_i,
  output rd_rsp_t      rsp_o,
  output int           req_count_o
);

  timeunit 1ns;
  timeprecision 1ps;

  inst_t mem [64];  // written by the testbench before each test

  logic  busy;
  int    wait_cnt;
  addr_t addr_q;

  always @(posedge clk) begin
    if (rst) begin
      busy        <= 1'b0;
      rsp_o       <= '0;
      req_count_o <= 0;
    end else begin
      rsp_o.valid <= 1'b0;
      if (req_i.valid) begin
        busy        <= 1'b1;
        addr_q      <= req_i.addr;
        wait_cnt    <= $urandom_range(0, 3);  // answer 1 to 4 cycles later
        req_count_o <= req_count_o + 1;
      end else if (busy) begin
        if (wait_cnt == 0) begin
          rsp_o.valid <= 1'b1;
          rsp_o.data  <= mem[addr_q[7:2]];
          busy        <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/fetch_unit_tb.sv
`default_nettype none

`include "fetch_config.svh"

module fetch_unit_tb
  import fetch_types_pkg::*;
  import fetch_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    n_tests    = 6;
  localparam int    res_delay  = 2;  // cycles from accept to resolve
  localparam int    max_cycles = 3000;
  localparam inst_t addi_w     = 32'h0010_8093;
  localparam inst_t lw_w       = 32'h0000_2103;
  localparam inst_t beq_w      = 32'h0000_0063;
  localparam inst_t jal_w      = 32'h0000_006f;
  localparam inst_t fence_w    = `INST_FENCE_I;

  logic       clk = 1'b0;
  logic       rst = 1'b1;
  rd_req_t    rd_req;
  rd_rsp_t    rd_rsp;
  resolve_t   resolve;
  logic       next_ready;
  fetch_out_t fetch;
  logic       valid;
  logic       spec;
  logic       good_spec;
  logic       bad_spec;
  int         req_count;

  // per test: program words (0 means fill pattern), resolves, expected results
  string test_name [n_tests] = '{"straight", "loop", "load", "predict", "mispredict", "fence"};
  inst_t prog [n_tests][8] = '{
    '{0, 0, 0, 0, 0, 0, 0, 0},
    '{addi_w, addi_w, addi_w, beq_w, 0, 0, 0, 0},
    '{addi_w, lw_w, addi_w, addi_w, 0, 0, 0, 0},
    '{addi_w, addi_w, beq_w, 0, 0, 0, 0, 0},
    '{addi_w, addi_w, beq_w, 0, 0, 0, 0, 0},
    '{addi_w, addi_w, fence_w, jal_w, 0, 0, 0, 0}
  };
  bit ready_rand [n_tests] = '{1, 0, 0, 0, 0, 0};
  int res_n      [n_tests] = '{0, 2, 1, 2, 2, 1};
  bit res_redir  [n_tests][2] = '{'{0, 0}, '{1, 1}, '{0, 0}, '{1, 1}, '{1, 0}, '{1, 0}};
  int res_off    [n_tests][2] = '{'{0, 0}, '{0, 0}, '{16, 0}, '{0, 0}, '{0, 12}, '{0, 0}};
  int exp_n      [n_tests] = '{10, 8, 4, 8, 10, 7};
  int exp_off    [n_tests][10] = '{
    '{0, 4, 8, 12, 16, 20, 24, 28, 32, 36},
    '{0, 4, 8, 12, 0, 4, 8, 12, 0, 0},
    '{0, 4, 16, 20, 0, 0, 0, 0, 0, 0},
    '{0, 4, 8, 0, 4, 8, 0, 4, 0, 0},
    '{0, 4, 8, 0, 4, 8, 12, 16, 20, 24},
    '{0, 4, 8, 12, 0, 4, 8, 0, 0, 0}
  };
  int exp_reqs [n_tests] = '{10, 4, 4, 4, 8, 8};
  int exp_good [n_tests] = '{0, 1, 0, 1, 0, 0};
  int exp_bad  [n_tests] = '{0, 0, 0, 0, 1, 0};
  bit exp_spec [n_tests] = '{0, 0, 0, 1, 1, 0};

  int       errors = 0;
  int       checks = 0;
  int       cur;
  int       cyc;
  bit       timed_out = 1'b0;
  addr_t    seen_pc [$];
  int       due_q [$];
  resolve_t res_q [$];

  always #50 clk = ~clk;

  fetch_unit UUT (
    .clk          (clk),
    .rst          (rst),
    .rd_req_o     (rd_req),
    .rd_rsp_i     (rd_rsp),
    .resolve_i    (resolve),
    .next_ready_i (next_ready),
    .fetch_o      (fetch),
    .valid_o      (valid),
    .spec_o       (spec),
    .good_spec_o  (good_spec),
    .bad_spec_o   (bad_spec)
  );

  fetch_mem_model u_mem (
    .clk         (clk),
    .rst         (rst),
    .req_i       (rd_req),
    .rsp_o       (rd_rsp),
    .req_count_o (req_count)
  );

  function automatic inst_t fill_word(addr_t a);
    return {a[31:7] ^ a[26:2], 7'h13};  // always an op-imm, never a hazard
  endfunction

  function automatic inst_t word_at(int t, addr_t a);
    int i;
    i = int'((a - `FETCH_PC_INIT) >> 2);
    if (i >= 0 && i < 8 && prog[t][i] != 0) return prog[t][i];
    return fill_word(a);
  endfunction

  // class a word must be reported with, from its opcode
  function automatic inst_class_e expected_class(inst_t w);
    logic [6:0] op;
    op = w[6:0];
    if (w == `INST_FENCE_I) return FENCE;
    if (op == `OP_LOAD) return LOAD;
    if (op == `OP_JAL || op == `OP_JALR || op == `OP_BRANCH || op == `OP_SYSTEM) return CTRL;
    return PLAIN;
  endfunction

  task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name[cur], what, exp, act);
    end
  endtask

  task automatic run_test(int t);
    int          spec_run;
    int          good_n;
    int          bad_n;
    int          ri;
    int          cycles;
    int          tail;
    int          reqs;
    bit          spec_seen;
    inst_t       w;
    inst_class_e c;
    resolve_t    r;
    spec_run = 0;
    good_n = 0;
    bad_n = 0;
    ri = 0;
    cycles = 0;
    tail = 0;
    reqs = 0;
    spec_seen = 1'b0;
    cur = t;
    for (int i = 0; i < 64; i++) begin
      u_mem.mem[i] = word_at(t, `FETCH_PC_INIT + 32'(i * 4));
    end
    seen_pc.delete();
    due_q.delete();
    res_q.delete();
    @(posedge clk);
    rst <= 1'b1;
    next_ready <= 1'b0;
    resolve <= '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    cyc = 0;
    while (seen_pc.size() < exp_n[t] || due_q.size() != 0 || tail < 3) begin
      @(negedge clk);
      cycles++;
      if (cycles > max_cycles) begin
        timed_out = 1'b1;
        $display("timeout: test %s did not finish in %0d cycles", test_name[t], max_cycles);
        return;
      end
      if (seen_pc.size() >= exp_n[t] && due_q.size() == 0) tail++;
      if (good_spec) begin
        good_n++;
        spec_run = 0;
      end
      if (bad_spec) begin
        bad_n++;
        repeat (spec_run) void'(seen_pc.pop_back());  // wrong path is dropped
        spec_run = 0;
      end
      if (valid && next_ready) begin
        w = word_at(t, fetch.pc);
        c = expected_class(w);
        check_val("instruction", w, fetch.inst);
        check_val("class", 32'(c), 32'(fetch.cls));
        seen_pc.push_back(fetch.pc);
        if (spec) begin
          spec_seen = 1'b1;
          spec_run++;
        end else begin
          spec_run = 0;
        end
        if (c == LOAD || c == CTRL) begin
          if (ri >= res_n[t]) begin
            errors++;
            $display("test %s: hazard at pc %0h has no resolve left", test_name[t], fetch.pc);
          end else begin
            r.valid    = 1'b1;
            r.redirect = res_redir[t][ri];
            r.next_pc  = `FETCH_PC_INIT + 32'(res_off[t][ri]);
            res_q.push_back(r);
            due_q.push_back(cyc + res_delay);
            ri++;
          end
        end
        reqs = req_count;
      end
      @(posedge clk);
      cyc++;
      next_ready <= (seen_pc.size() >= exp_n[t]) ? 1'b0 :
                    ready_rand[t] ? 1'($urandom_range(0, 1)) : 1'b1;
      resolve <= '0;
      if (due_q.size() != 0 && due_q[0] == cyc) begin
        resolve <= res_q.pop_front();
        void'(due_q.pop_front());
      end
    end
    check_val("deliveries", exp_n[t], seen_pc.size());
    for (int i = 0; i < exp_n[t] && i < seen_pc.size(); i++) begin
      check_val($sformatf("pc %0d", i), `FETCH_PC_INIT + 32'(exp_off[t][i]), seen_pc[i]);
    end
    check_val("bus requests", exp_reqs[t], reqs);
    check_val("good_spec pulses", exp_good[t], good_n);
    check_val("bad_spec pulses", exp_bad[t], bad_n);
    check_val("speculative accepts", 32'(exp_spec[t]), 32'(spec_seen));
    check_val("resolves sent", res_n[t], ri);
  endtask

  initial begin
    void'($urandom(32'hcb55bd88));
    next_ready = 1'b0;
    resolve = '0;
    for (int t = 0; t < n_tests && !timed_out; t++) begin
      run_test(t);
    end
    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_unit.f
+incdir+hw
hw/fetch_types_pkg.sv
hw/fetch_bus_pkg.sv
hw/fetch_pc_ctrl.sv
hw/l1i_cache.sv
hw/fetch_predecode.sv
hw/fetch_unit.sv
bench/fetch_mem_model.sv
bench/fetch_unit_tb.sv

//--- hw/fetch_bus_pkg.sv
`default_nettype none

package fetch_bus_pkg;

  import fetch_types_pkg::*;

  // one word read, strobed for a single cycle
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic  valid;
    inst_t data;
  } rd_rsp_t;

  // back end report for a load or control transfer
  typedef struct packed {
    logic  valid;
    logic  redirect;  // control flow left the fall-through path
    addr_t next_pc;
  } resolve_t;

  typedef struct packed {
    addr_t       pc;
    inst_t       inst;
    inst_class_e cls;
  } fetch_out_t;

endpackage

`default_nettype wire

//--- hw/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// fetch starts here after reset
`define FETCH_PC_INIT 32'h8000_0000

// 4 sets of 2-word lines
`define L1I_SETS_LOG2 2
`define L1I_LINE_LOG2 1

// major opcodes seen by predecode
`define OP_JAL    7'b110_1111
`define OP_JALR   7'b110_0111
`define OP_BRANCH 7'b110_0011
`define OP_SYSTEM 7'b111_0011
`define OP_LOAD   7'b000_0011

`define INST_FENCE_I 32'h0000_100f  // fence.i, all fields zero

`endif

//--- hw/fetch_pc_ctrl.sv
`default_nettype none

`include "fetch_config.svh"

module fetch_pc_ctrl
  import fetch_types_pkg::*;
  import fetch_bus_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire resolve_t    resolve_i,
  input  wire logic        accept_i,
  input  wire inst_class_e accept_class_i,
  output addr_t            pc_o,
  output logic             stall_o,
  output logic             spec_o,
  output logic             good_spec_o,
  output logic             bad_spec_o
);

  typedef enum logic [1:0] {
    RUN,
    WAIT_RESOLVE,
    SPECULATE
  } pc_state_e;

  pc_state_e state_q;
  addr_t     pc_q;
  addr_t     btb_q;        // one-entry branch target
  logic      btb_valid_q;
  addr_t     pred_q;       // target we jumped to on the last prediction
  logic      hold_q;       // hazard accepted while a prediction is open
  logic      good_q;
  logic      bad_q;

  logic hazard;
  logic pred_ok;

  assign hazard  = (accept_class_i == LOAD) || (accept_class_i == CTRL);
  assign pred_ok = (resolve_i.next_pc == pred_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= RUN;
      pc_q        <= `FETCH_PC_INIT;
      btb_valid_q <= 1'b0;
      hold_q      <= 1'b0;
      good_q      <= 1'b0;
      bad_q       <= 1'b0;
    end else begin
      good_q <= 1'b0;
      bad_q  <= 1'b0;

      if (resolve_i.valid && resolve_i.redirect) begin  // train on every taken transfer
        btb_q       <= resolve_i.next_pc;
        btb_valid_q <= 1'b1;
      end

      case (state_q)
        RUN: begin
          if (accept_i) begin
            if (!hazard) begin
              pc_q <= pc_q + 32'd4;
            end else if (accept_class_i == CTRL && btb_valid_q) begin
              pc_q    <= btb_q;
              pred_q  <= btb_q;
              state_q <= SPECULATE;
            end else begin
              state_q <= WAIT_RESOLVE;  // pc parks on the hazard
            end
          end
        end

        WAIT_RESOLVE: begin
          if (resolve_i.valid) begin
            pc_q    <= resolve_i.next_pc;
            state_q <= RUN;
          end
        end

        SPECULATE: begin
          if (resolve_i.valid) begin
            hold_q <= 1'b0;
            if (pred_ok) begin
              good_q <= 1'b1;
              // a held hazard still owes its own resolve
              if (hold_q || (accept_i && hazard)) begin
                state_q <= WAIT_RESOLVE;
              end else begin
                state_q <= RUN;
                if (accept_i) begin
                  pc_q <= pc_q + 32'd4;
                end
              end
            end else begin
              // wrong path, anything accepted now is dropped by the back end
              bad_q   <= 1'b1;
              pc_q    <= resolve_i.next_pc;
              state_q <= RUN;
            end
          end else if (accept_i) begin
            if (hazard) begin
              hold_q <= 1'b1;
            end else begin
              pc_q <= pc_q + 32'd4;
            end
          end
        end

        default: state_q <= RUN;
      endcase
    end
  end

  assign pc_o        = pc_q;
  assign stall_o     = (state_q == WAIT_RESOLVE) || hold_q || bad_q;  // bad_q retracts a stale offer
  assign spec_o      = (state_q == SPECULATE);
  assign good_spec_o = good_q;
  assign bad_spec_o  = bad_q;

  // the back end only resolves what we are waiting on or speculating past
  a_no_resolve_in_run: assert property (
    @(posedge clk) disable iff (rst) resolve_i.valid |-> state_q != RUN
  );

endmodule

`default_nettype wire

//--- hw/fetch_predecode.sv
`default_nettype none

`include "fetch_config.svh"

module fetch_predecode
  import fetch_types_pkg::*;
  import fetch_bus_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire addr_t pc_i,
  input  wire inst_t inst_i,
  input  wire logic  hit_i,
  input  wire logic  stall_i,
  input  wire logic  next_ready_i,
  output fetch_out_t fetch_o,
  output logic       valid_o,
  output logic       accept_o,
  output inst_class_e accept_class_o,
  output logic       flush_o
);

  inst_class_e cls;
  logic [6:0]  opcode;

  assign opcode = inst_i[6:0];

  always_comb begin
    if (inst_i == `INST_FENCE_I) begin
      cls = FENCE;
    end else begin
      case (opcode)
        `OP_LOAD: cls = LOAD;
        `OP_JAL, `OP_JALR, `OP_BRANCH, `OP_SYSTEM: cls = CTRL;
        default: cls = PLAIN;
      endcase
    end
  end

  assign valid_o = hit_i && !stall_i;
  assign fetch_o = '{pc: pc_i, inst: inst_i, cls: cls};

  assign accept_o       = valid_o && next_ready_i;
  assign accept_class_o = cls;
  assign flush_o        = accept_o && (cls == FENCE);  // cache drops all lines next edge

  // an offer holds until taken; only a mispredict may withdraw it
  a_offer_stable: assert property (
    @(posedge clk) disable iff (rst)
    valid_o && !next_ready_i |=> !valid_o || $stable(fetch_o)
  );

endmodule

`default_nettype wire

//--- hw/fetch_types_pkg.sv
`default_nettype none

`include "fetch_config.svh"

package fetch_types_pkg;

  // byte address, always word aligned inside the fetch unit
  typedef logic [31:0] addr_t;

  typedef logic [31:0] inst_t;

  // address bits above set index and word offset
  typedef logic [31-`L1I_SETS_LOG2-`L1I_LINE_LOG2-2:0] l1i_tag_t;

  typedef logic [`L1I_SETS_LOG2-1:0] l1i_idx_t;

  // what the pc logic needs to know about an accepted instruction
  typedef enum logic [1:0] {
    PLAIN = 2'd0,  // falls through to pc+4
    LOAD  = 2'd1,  // waits for the resolved next pc
    CTRL  = 2'd2,  // jal, jalr, branch, system
    FENCE = 2'd3   // fence.i, drops the cache contents
  } inst_class_e;

endpackage

`default_nettype wire

//--- hw/fetch_unit.sv
`default_nettype none

module fetch_unit
  import fetch_types_pkg::*;
  import fetch_bus_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  output rd_req_t       rd_req_o,
  input  wire rd_rsp_t  rd_rsp_i,
  input  wire resolve_t resolve_i,
  input  wire logic     next_ready_i,
  output fetch_out_t    fetch_o,
  output logic          valid_o,
  output logic          spec_o,
  output logic          good_spec_o,
  output logic          bad_spec_o
);

  addr_t       pc;
  inst_t       inst;
  logic        hit;
  logic        stall;
  logic        accept;
  inst_class_e accept_class;
  logic        flush;

  fetch_pc_ctrl u_pc_ctrl (
    .clk            (clk),
    .rst            (rst),
    .resolve_i      (resolve_i),
    .accept_i       (accept),
    .accept_class_i (accept_class),
    .pc_o           (pc),
    .stall_o        (stall),
    .spec_o         (spec_o),
    .good_spec_o    (good_spec_o),
    .bad_spec_o     (bad_spec_o)
  );

  l1i_cache u_cache (
    .clk      (clk),
    .rst      (rst),
    .pc_i     (pc),
    .flush_i  (flush),
    .hit_o    (hit),
    .inst_o   (inst),
    .rd_req_o (rd_req_o),
    .rd_rsp_i (rd_rsp_i)
  );

  fetch_predecode u_predecode (
    .clk            (clk),
    .rst            (rst),
    .pc_i           (pc),
    .inst_i         (inst),
    .hit_i          (hit),
    .stall_i        (stall),
    .next_ready_i   (next_ready_i),
    .fetch_o        (fetch_o),
    .valid_o        (valid_o),
    .accept_o       (accept),
    .accept_class_o (accept_class),
    .flush_o        (flush)
  );

endmodule

`default_nettype wire

//--- hw/l1i_cache.sv
`default_nettype none

`include "fetch_config.svh"

module l1i_cache
  import fetch_types_pkg::*;
  import fetch_bus_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    rst,
  input  wire addr_t   pc_i,
  input  wire logic    flush_i,
  output logic         hit_o,
  output inst_t        inst_o,
  output rd_req_t      rd_req_o,
  input  wire rd_rsp_t rd_rsp_i
);

  localparam int n_sets  = 1 << `L1I_SETS_LOG2;
  localparam int n_words = 1 << `L1I_LINE_LOG2;
  localparam int off_lsb = 2;
  localparam int idx_lsb = off_lsb + `L1I_LINE_LOG2;
  localparam int tag_lsb = idx_lsb + `L1I_SETS_LOG2;

  typedef enum logic [2:0] {
    IDLE,
    REQ_EVEN,
    WAIT_EVEN,
    REQ_ODD,
    WAIT_ODD,
    FILL
  } refill_state_e;

  refill_state_e state_q;

  inst_t           data_q [n_sets][n_words];
  l1i_tag_t        tag_q  [n_sets];
  logic [n_sets-1:0] valid_q;

  // line being refilled, captured when the miss is seen
  l1i_tag_t fill_tag_q;
  l1i_idx_t fill_idx_q;

  l1i_tag_t                  pc_tag;
  l1i_idx_t                  pc_idx;
  logic [`L1I_LINE_LOG2-1:0] pc_off;

  assign pc_tag = pc_i[31:tag_lsb];
  assign pc_idx = pc_i[tag_lsb-1:idx_lsb];
  assign pc_off = pc_i[idx_lsb-1:off_lsb];

  // lookup straight from the arrays, only while no refill runs
  assign hit_o  = (state_q == IDLE) && valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign inst_o = data_q[pc_idx][pc_off];

  always_comb begin
    rd_req_o.valid = (state_q == REQ_EVEN) || (state_q == REQ_ODD);
    rd_req_o.addr  = {fill_tag_q, fill_idx_q, state_q == REQ_ODD, 2'b00};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (!hit_o) begin
            state_q         <= REQ_EVEN;
            valid_q[pc_idx] <= 1'b0;  // the old line is overwritten from here on
          end
        end
        REQ_EVEN: state_q <= WAIT_EVEN;
        WAIT_EVEN: begin
          if (rd_rsp_i.valid) begin
            state_q <= REQ_ODD;
          end
        end
        REQ_ODD: state_q <= WAIT_ODD;
        WAIT_ODD: begin
          if (rd_rsp_i.valid) begin
            state_q <= FILL;
          end
        end
        FILL: begin
          valid_q[fill_idx_q] <= 1'b1;
          state_q             <= IDLE;
        end
        default: state_q <= IDLE;
      endcase

      // fence.i wins over any valid update in the same cycle
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      fill_tag_q <= pc_tag;
      fill_idx_q <= pc_idx;
    end
    if (state_q == WAIT_EVEN && rd_rsp_i.valid) begin
      data_q[fill_idx_q][0] <= rd_rsp_i.data;
    end
    if (state_q == WAIT_ODD && rd_rsp_i.valid) begin
      data_q[fill_idx_q][1] <= rd_rsp_i.data;
      tag_q[fill_idx_q]     <= fill_tag_q;
    end
  end

  // memory only answers a request we are waiting on
  a_rsp_when_waiting: assert property (
    @(posedge clk) disable iff (rst)
    rd_rsp_i.valid |-> (state_q == WAIT_EVEN) || (state_q == WAIT_ODD)
  );

  // a half written line must never look valid before its fill completes
  a_refill_line_invalid: assert property (
    @(posedge clk) disable iff (rst) (state_q != IDLE) |-> !valid_q[fill_idx_q]
  );

endmodule

`default_nettype wire
